//--- design/async_fifo.sv
`include "spi_link_params.svh"

module async_fifo #(
  parameter int DATA_W = `SPI_WIDTH,
  parameter int ADDR_W = `FIFO_AW
) (
  input  logic              reset_n_chip,
  input  logic              clk_chip,
  input  logic              wr_en,
  input  logic [DATA_W-1:0] din,
  input  logic              spi_sck,
  input  logic              rd_en,
  output logic [DATA_W-1:0] dout,
  output logic              almost_full,
  output logic              full
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  logic [ADDR_W:0] wr_bin;
  logic [ADDR_W:0] wr_bin_next;
  logic [ADDR_W:0] wr_gray;
  logic [ADDR_W:0] rd_gray_w1;
  logic [ADDR_W:0] rd_gray_w2;  // read ptr in write domain
  logic [ADDR_W:0] rd_bin_w;
  logic [ADDR_W:0] level_next;  // fill after this cycle's write

  logic [ADDR_W:0] rd_bin;
  logic [ADDR_W:0] rd_bin_next;
  logic [ADDR_W:0] rd_gray;
  logic [ADDR_W:0] wr_gray_r1;
  logic [ADDR_W:0] wr_gray_r2;  // write ptr in read domain
  logic            empty;
  logic            pop;

  function automatic logic [ADDR_W:0] gray2bin(input logic [ADDR_W:0] g);
    logic [ADDR_W:0] b;
    b[ADDR_W] = g[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // ====================
  // write side
  // ====================
  assign wr_bin_next = wr_bin + {{ADDR_W{1'b0}}, wr_en};
  assign rd_bin_w    = gray2bin(rd_gray_w2);
  assign level_next  = wr_bin_next - rd_bin_w;
  assign full = (wr_gray == {~rd_gray_w2[ADDR_W:ADDR_W-1], rd_gray_w2[ADDR_W-2:0]});

  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_w1  <= '0;
      rd_gray_w2  <= '0;
      almost_full <= 1'b0;
    end else begin
      wr_bin      <= wr_bin_next;
      wr_gray     <= wr_bin_next ^ (wr_bin_next >> 1);
      rd_gray_w1  <= rd_gray;
      rd_gray_w2  <= rd_gray_w1;
      almost_full <= (level_next >= DEPTH - `FULL_LEVEL_GAP);  // pessimistic on read lag
    end
  end

  always_ff @(posedge clk_chip) begin
    if (wr_en) begin
      mem[wr_bin[ADDR_W-1:0]] <= din;
    end
  end

  // ====================
  // read side
  // ====================
  assign empty       = (rd_gray == wr_gray_r2);
  assign pop         = rd_en & ~empty;
  assign rd_bin_next = rd_bin + {{ADDR_W{1'b0}}, pop};
  assign dout        = mem[rd_bin[ADDR_W-1:0]];  // show-ahead head word

  always_ff @(posedge spi_sck or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      rd_bin     <= rd_bin_next;
      rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
    end
  end

  a_no_write_full : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip)
    wr_en |-> !full
  ) else $error("write into full fifo");

endmodule

//--- design/burst_counter.sv
module burst_counter (
  input  logic       clk_chip,
  input  logic       reset_n_chip,
  link_cfg_if.cnt    cfg,
  input  logic       accept,      // word taken this cycle
  input  logic       state_idle,
  output logic       done
);

  spi_link_pkg::tx_count_t count;
  spi_link_pkg::tx_count_t count_inc;

  assign count_inc = count + 1'b1;

  // ====================
  // word count
  // ====================
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      count <= '0;
    end else if (state_idle) begin
      count <= '0;              // new burst starts from zero
    end else if (accept) begin
      count <= count_inc;
    end
  end

  // set together with the last count, so done is up the next cycle
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      done <= 1'b0;
    end else if (state_idle) begin
      done <= 1'b0;
    end else if (accept && (count_inc == cfg.burst_size)) begin
      done <= 1'b1;             // hold until idle
    end
  end

  // done must shut wr_ready at the top before another word arrives
  a_no_accept_after_done : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip)
    accept |-> !done
  ) else $error("word accepted after burst done");

endmodule

//--- design/config_header.sv
`include "spi_link_params.svh"

module config_header (
  input  logic                      clk_chip,
  input  logic                      reset_n_chip,
  input  logic                      config_pulse,
  input  spi_link_pkg::cfg_code_t   config_data,
  input  spi_link_pkg::reset_code_t reset_if_cfg,
  input  logic                      config_ready,
  link_cfg_if.src                   cfg,
  input  spi_link_pkg::spi_word_t   fifo_dout,
  input  logic                      spi_cs_n,
  input  logic                      cs_n_d,
  output spi_link_pkg::spi_word_t   spi_data
);

  spi_link_pkg::spi_word_t header_word;

  assign cfg.cfg_load = config_pulse & config_ready;  // only taken in idle

  // ====================
  // config latch
  // ====================
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cfg.cfg_code   <= '0;
      cfg.reset_code <= '0;
      cfg.burst_size <= `WR_SIZE_FLGOFM;
    end else if (cfg.cfg_load) begin
      cfg.cfg_code   <= config_data;
      cfg.reset_code <= reset_if_cfg;
      case (config_data)
        `IFCODE_FLGOFM: cfg.burst_size <= `WR_SIZE_FLGOFM;
        `IFCODE_OFM:    cfg.burst_size <= `WR_SIZE_OFM;
        default:        cfg.burst_size <= `WR_SIZE_FLGOFM;
      endcase
    end
  end

  assign header_word = {cfg.cfg_code, cfg.reset_code, {`HDR_PAD_W{1'b0}}};

  // header until the fpga selects and one sck edge after it lets go
  assign spi_data = (spi_cs_n && cs_n_d) ? header_word : fifo_dout;

endmodule

//--- design/cs_sync.sv
module cs_sync (
  input  logic clk_chip,
  input  logic reset_n_chip,
  input  logic spi_sck,
  input  logic spi_cs_n,
  output logic cs_n_d,       // sck domain
  output logic cs_n_sync,
  output logic cs_n_d_sync
);

  logic [2:0] cs_pipe;    // [2] is the synced output
  logic [2:0] cs_d_pipe;

  // one sck edge behind the fpga select
  always_ff @(posedge spi_sck or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cs_n_d <= 1'b1;
    end else begin
      cs_n_d <= spi_cs_n;
    end
  end

  // ====================
  // into clk_chip
  // ====================
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      cs_pipe   <= 3'b111;  // deselected
      cs_d_pipe <= 3'b111;
    end else begin
      cs_pipe   <= {cs_pipe[1:0], spi_cs_n};
      cs_d_pipe <= {cs_d_pipe[1:0], cs_n_d};
    end
  end

  assign cs_n_sync   = cs_pipe[2];
  assign cs_n_d_sync = cs_d_pipe[2];

  // delayed select trails the live one by at least a cycle
  a_cs_d_after_cs : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip)
    $rose(cs_n_d_sync) |-> $past(cs_n_sync)
  ) else $error("delayed select rose before select");

endmodule

//--- design/link_cfg_if.sv
interface link_cfg_if (
  input logic clk_chip
);

  logic                      cfg_load;    // qualified config pulse
  spi_link_pkg::cfg_code_t   cfg_code;    // latched code
  spi_link_pkg::reset_code_t reset_code;  // latched reset field
  spi_link_pkg::tx_count_t   burst_size;  // words to accept

  modport src (
    input  clk_chip,
    output cfg_load,
    output cfg_code,
    output reset_code,
    output burst_size
  );

  modport ctrl (
    input clk_chip,
    input cfg_load
  );

  modport cnt (
    input clk_chip,
    input burst_size
  );

endinterface

//--- design/spi_link_params.svh
`ifndef SPI_LINK_PARAMS_SVH
`define SPI_LINK_PARAMS_SVH

// ====================
// widths and depth
// ====================
`define SPI_WIDTH        32        // parallel bus to fpga
`define FIFO_AW          3         // depth 8
`define TX_WIDTH         20        // burst counter width
`define FULL_LEVEL_GAP   2         // almost-full at depth minus gap

// ====================
// config codes
// ====================
`define IFCODE_FLGOFM    4'd1
`define IFCODE_OFM       4'd2
`define WR_SIZE_FLGOFM   20'd16    // also used for unknown codes
`define WR_SIZE_OFM      20'd40

// header word: code in [31:28], reset field in [27:25], zeros below
`define HDR_PAD_W        25

`endif

//--- design/spi_link_pkg.sv
`include "spi_link_params.svh"

package spi_link_pkg;

  // ====================
  // data and count types
  // ====================
  typedef logic [`SPI_WIDTH-1:0] spi_word_t;    // one bus word
  typedef logic [`TX_WIDTH-1:0]  tx_count_t;    // words per burst
  typedef logic [3:0]            cfg_code_t;    // interface code
  typedef logic [2:0]            reset_code_t;  // reset field to fpga
  typedef logic [`FIFO_AW:0]     fifo_ptr_t;    // extra msb for wrap

  // ====================
  // write path fsm
  // ====================
  typedef enum logic [2:0] {
    IDLE,     // waiting for a config pulse
    CONFIG,   // code latched
    WAIT_CS,  // config_req up, waiting for select
    XFER,     // fpga is reading
    DONE_CS   // select ended
  } wr_state_e;

endpackage

//--- design/spi_wr_link_top.sv
`include "spi_link_params.svh"

module spi_wr_link_top (
  input  logic                      clk_chip,
  input  logic                      reset_n_chip,
  input  logic                      spi_sck,
  input  logic                      spi_cs_n,
  input  logic                      config_pulse,
  input  spi_link_pkg::cfg_code_t   config_data,
  input  spi_link_pkg::reset_code_t reset_if_cfg,
  input  logic                      gbf_val,
  input  logic                      wr_req,
  input  spi_link_pkg::spi_word_t   wr_data,
  output spi_link_pkg::spi_word_t   spi_data,
  output logic                      config_req,
  output logic                      config_ready,
  output logic                      wr_ready
);

  spi_link_pkg::spi_word_t fifo_dout;
  logic cs_n_d;       // sck domain
  logic cs_n_sync;
  logic cs_n_d_sync;
  logic almost_full;
  logic done;
  logic state_idle;
  logic wr_en;

  assign wr_en = wr_req & wr_ready;  // accepted word

  link_cfg_if u_cfg_if (.clk_chip(clk_chip));

  config_header u_config_header (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .config_pulse (config_pulse),
    .config_data  (config_data),
    .reset_if_cfg (reset_if_cfg),
    .config_ready (config_ready),
    .cfg          (u_cfg_if.src),
    .fifo_dout    (fifo_dout),
    .spi_cs_n     (spi_cs_n),
    .cs_n_d       (cs_n_d),
    .spi_data     (spi_data)
  );

  cs_sync u_cs_sync (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .spi_sck      (spi_sck),
    .spi_cs_n     (spi_cs_n),
    .cs_n_d       (cs_n_d),
    .cs_n_sync    (cs_n_sync),
    .cs_n_d_sync  (cs_n_d_sync)
  );

  write_ctrl u_write_ctrl (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .cfg          (u_cfg_if.ctrl),
    .cs_n_sync    (cs_n_sync),
    .cs_n_d_sync  (cs_n_d_sync),
    .almost_full  (almost_full),
    .done         (done),
    .gbf_val      (gbf_val),
    .config_req   (config_req),
    .config_ready (config_ready),
    .wr_ready     (wr_ready),
    .state_idle   (state_idle)
  );

  burst_counter u_burst_counter (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .cfg          (u_cfg_if.cnt),
    .accept       (wr_en),
    .state_idle   (state_idle),
    .done         (done)
  );

  async_fifo #(
    .DATA_W (`SPI_WIDTH),
    .ADDR_W (`FIFO_AW)
  ) u_async_fifo (
    .reset_n_chip (reset_n_chip),
    .clk_chip     (clk_chip),
    .wr_en        (wr_en),
    .din          (wr_data),
    .spi_sck      (spi_sck),
    .rd_en        (~spi_cs_n),   // pop while selected
    .dout         (fifo_dout),
    .almost_full  (almost_full),
    .full         ()             // wr_ready already guards it
  );

endmodule

//--- design/write_ctrl.sv
module write_ctrl (
  input  logic    clk_chip,
  input  logic    reset_n_chip,
  link_cfg_if.ctrl cfg,
  input  logic    cs_n_sync,
  input  logic    cs_n_d_sync,
  input  logic    almost_full,
  input  logic    done,
  input  logic    gbf_val,
  output logic    config_req,
  output logic    config_ready,
  output logic    wr_ready,
  output logic    state_idle
);

  spi_link_pkg::wr_state_e state;

  // ====================
  // fsm
  // ====================
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      state <= spi_link_pkg::IDLE;
    end else begin
      case (state)
        spi_link_pkg::IDLE:    if (cfg.cfg_load) state <= spi_link_pkg::CONFIG;
        spi_link_pkg::CONFIG:  state <= spi_link_pkg::WAIT_CS;
        spi_link_pkg::WAIT_CS: if (!cs_n_sync) state <= spi_link_pkg::XFER;
        // both selects high means the last sck edge is past
        spi_link_pkg::XFER:    if (cs_n_sync && cs_n_d_sync) state <= spi_link_pkg::DONE_CS;
        spi_link_pkg::DONE_CS: state <= spi_link_pkg::IDLE;
        default:               state <= spi_link_pkg::IDLE;
      endcase
    end
  end

  // request to fpga until the select is seen
  always_ff @(posedge clk_chip or negedge reset_n_chip) begin
    if (!reset_n_chip) begin
      config_req <= 1'b0;
    end else if (state == spi_link_pkg::CONFIG) begin
      config_req <= 1'b1;
    end else if (state == spi_link_pkg::WAIT_CS && !cs_n_sync) begin
      config_req <= 1'b0;  // low on first xfer cycle
    end
  end

  assign state_idle   = (state == spi_link_pkg::IDLE);
  assign config_ready = state_idle;
  assign wr_ready     = !state_idle && !almost_full && !done && gbf_val;

  a_no_req_idle : assert property (
    @(posedge clk_chip) disable iff (!reset_n_chip)
    state_idle |-> !config_req
  ) else $error("config_req while idle");

endmodule

//--- files.f
+incdir+design
design/spi_link_pkg.sv
design/link_cfg_if.sv
design/cs_sync.sv
design/async_fifo.sv
design/burst_counter.sv
design/write_ctrl.sv
design/config_header.sv
design/spi_wr_link_top.sv
test/tb_spi_wr_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the write link testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_spi_wr_link -Mdir obj_dir

if ./obj_dir/Vtb_spi_wr_link | tee /dev/stderr | grep "All tests passed" > /dev/null; then
  echo "simulation PASS"
else
  echo "simulation FAIL"
  exit 1
fi

//--- test/tb_spi_wr_link.sv
`include "spi_link_params.svh"

module tb_spi_wr_link;

  logic                      clk_chip;
  logic                      reset_n_chip;
  logic                      spi_sck;
  logic                      spi_cs_n;
  logic                      config_pulse;
  spi_link_pkg::cfg_code_t   config_data;
  spi_link_pkg::reset_code_t reset_if_cfg;
  logic                      gbf_val;
  logic                      wr_req;
  spi_link_pkg::spi_word_t   wr_data;
  spi_link_pkg::spi_word_t   spi_data;
  logic                      config_req;
  logic                      config_ready;
  logic                      wr_ready;

  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          sck_edges;     // rising sck edges so far
  int          acc_count;     // words accepted this burst
  int          reads_done;    // words read this burst
  int          exp_size;
  bit          stim_on;
  bit          burst_active;  // fpga may select
  bit          selected;
  bit          sel_seen;
  bit          req_phase;     // config_req must hold until select

  spi_link_pkg::spi_word_t exp_words[$];  // accepted and not yet read
  longint                  wr_times[$];
  int                      wr_edges[$];   // sck edge count at write

  spi_wr_link_top u_dut (
    .clk_chip     (clk_chip),
    .reset_n_chip (reset_n_chip),
    .spi_sck      (spi_sck),
    .spi_cs_n     (spi_cs_n),
    .config_pulse (config_pulse),
    .config_data  (config_data),
    .reset_if_cfg (reset_if_cfg),
    .gbf_val      (gbf_val),
    .wr_req       (wr_req),
    .wr_data      (wr_data),
    .spi_data     (spi_data),
    .config_req   (config_req),
    .config_ready (config_ready),
    .wr_ready     (wr_ready)
  );

  // ====================
  // clocks
  // ====================
  initial begin
    clk_chip = 1'b0;
    forever #10 clk_chip = ~clk_chip;
  end

  initial begin
    spi_sck = 1'b0;
    forever #17 spi_sck = ~spi_sck;  // fpga serial clock
  end

  always @(posedge spi_sck) sck_edges++;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int size_for_code(input spi_link_pkg::cfg_code_t code);
    if (code == `IFCODE_OFM) begin
      return `WR_SIZE_OFM;
    end
    return `WR_SIZE_FLGOFM;  // code 1 and anything unknown
  endfunction

  function automatic spi_link_pkg::cfg_code_t pick_code(input int idx);
    spi_link_pkg::cfg_code_t c;
    c = spi_link_pkg::cfg_code_t'(rand_bits(4));
    if (idx == 0) begin
      c = `IFCODE_FLGOFM;
    end else if (idx == 1) begin
      c = `IFCODE_OFM;
    end else if (idx == 2 && (c == `IFCODE_FLGOFM || c == `IFCODE_OFM)) begin
      c = c + 4'd8;  // outside the table
    end
    return c;
  endfunction

  // ====================
  // checks
  // ====================
  task automatic compare_word(input spi_link_pkg::spi_word_t got,
                              input spi_link_pkg::spi_word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic require_flag(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("[ERROR] %0t: %s", $time, what);
    end
  endtask

  // ====================
  // chip side
  // ====================
  initial begin : chip_stimulus
    forever begin
      @(posedge clk_chip);
      #2;
      if (stim_on) begin
        gbf_val = (rand_bits(2) != 0);
        wr_req  = (rand_bits(2) != 0);
        wr_data = rand_bits(32);
      end
    end
  end

  initial begin : accept_monitor
    logic                    take;
    spi_link_pkg::spi_word_t data;
    forever begin
      @(negedge clk_chip);
      take = wr_req && wr_ready;  // accepted at the coming edge
      data = wr_data;
      if (reset_n_chip) begin
        require_flag(!(wr_ready && config_ready), "wr_ready high while config_ready");
        require_flag(gbf_val || !wr_ready, "wr_ready high while gbf_val low");
        if (req_phase && !sel_seen) begin
          require_flag(config_req, "config_req dropped before select");
        end
      end
      @(posedge clk_chip);
      if (take) begin
        exp_words.push_back(data);
        wr_times.push_back(longint'($time));
        wr_edges.push_back(sck_edges);
        acc_count++;
        require_flag(exp_words.size() <= (1 << `FIFO_AW), "more words held than fifo depth");
      end
    end
  end

  // ====================
  // fpga reader
  // ====================
  initial begin : fpga_reader
    forever begin
      @(posedge spi_sck);
      #4;
      if (selected && reads_done == exp_size) begin
        spi_cs_n = 1'b1;
        selected = 1'b0;
        burst_active = 1'b0;
      end else if (!selected && burst_active && exp_words.size() > 0) begin
        if ((longint'($time) - wr_times[0]) >= 80 && rand_bits(1) != 0) begin
          spi_cs_n = 1'b0;  // oldest word is 4 cycles old
          selected = 1'b1;
          sel_seen = 1'b1;
        end
      end
      #16;
      if (selected && reads_done < exp_size && exp_words.size() > 0) begin
        // write pointer needs two sck edges to reach the read side
        if ((sck_edges - wr_edges[0]) >= 2) begin
          compare_word(spi_data, exp_words[0], "fpga read word");
          void'(exp_words.pop_front());
          void'(wr_times.pop_front());
          void'(wr_edges.pop_front());
          reads_done++;
        end
      end
    end
  end

  // ====================
  // waits
  // ====================
  task automatic wait_config_ready(input int limit, inout bit ok);
    int n;
    n = 0;
    while (!config_ready && n < limit) begin
      @(negedge clk_chip);
      n++;
    end
    if (!config_ready) begin
      $display("timeout: config_ready did not return high");
      ok = 1'b0;
    end
  endtask

  task automatic wait_config_req(input int limit, inout bit ok);
    int n;
    n = 0;
    while (!config_req && n < limit) begin
      @(negedge clk_chip);
      n++;
    end
    if (!config_req) begin
      $display("timeout: config_req never rose after the config pulse");
      ok = 1'b0;
    end
  endtask

  task automatic wait_reads_done(input int limit, inout bit ok);
    int n;
    n = 0;
    while (burst_active && n < limit) begin
      @(negedge clk_chip);
      n++;
    end
    if (burst_active) begin
      $display("timeout: fpga did not read the whole burst, %0d words read", reads_done);
      ok = 1'b0;
    end
  endtask

  task automatic run_burst(input spi_link_pkg::cfg_code_t code,
                           input spi_link_pkg::reset_code_t rst, output bit ok);
    spi_link_pkg::spi_word_t hdr;
    ok = 1'b1;
    hdr = {code, rst, 25'd0};
    exp_size = size_for_code(code);
    acc_count = 0;
    reads_done = 0;
    sel_seen = 1'b0;
    wait_config_ready(20, ok);
    if (!ok) return;
    @(posedge clk_chip);
    #2;
    config_pulse = 1'b1;
    config_data = code;
    reset_if_cfg = rst;
    @(posedge clk_chip);
    #2;
    config_pulse = 1'b0;
    config_data = '0;  // latched copy must stay on the bus
    reset_if_cfg = '0;
    wait_config_req(20, ok);
    if (!ok) return;
    compare_word(spi_data, hdr, "header before select");
    req_phase = 1'b1;
    burst_active = 1'b1;
    wait_reads_done(4000, ok);
    if (!ok) return;
    wait_config_ready(50, ok);
    req_phase = 1'b0;
    if (!ok) return;
    compare_count(acc_count, exp_size, "accepted words in burst");
    require_flag(exp_words.size() == 0, "accepted words left unread after burst");
    compare_word(spi_data, hdr, "header after burst");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin : main_seq
    bit                        ok;
    spi_link_pkg::cfg_code_t   code;
    spi_link_pkg::reset_code_t rst;
    lfsr_state   = 32'he809_8961;
    checks       = 0;
    errors       = 0;
    stim_on      = 1'b0;
    burst_active = 1'b0;
    selected     = 1'b0;
    sel_seen     = 1'b0;
    req_phase    = 1'b0;
    reset_n_chip = 1'b0;
    spi_cs_n     = 1'b1;
    config_pulse = 1'b0;
    config_data  = '0;
    reset_if_cfg = '0;
    gbf_val      = 1'b0;
    wr_req       = 1'b0;
    wr_data      = '0;
    repeat (3) @(posedge clk_chip);
    #2;
    reset_n_chip = 1'b1;
    @(negedge clk_chip);
    require_flag(config_ready, "config_ready low after reset");
    require_flag(!config_req, "config_req high after reset");
    require_flag(!wr_ready, "wr_ready high after reset");
    compare_word(spi_data, '0, "header after reset");
    stim_on = 1'b1;
    ok = 1'b1;
    for (int b = 0; b < 5; b++) begin
      if (ok) begin
        code = pick_code(b);
        rst = spi_link_pkg::reset_code_t'(rand_bits(3));
        run_burst(code, rst, ok);
      end
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (ok && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
